// File: Makefile
VERILATOR ?= verilator
TOP       ?= udp_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/udp_pkg.sv
package udp_pkg;

  localparam int unsigned UDP_HDR_LEN  = 8;  // Bytes
  localparam int unsigned IPV4_HDR_LEN = 20; // Bytes, no options

  // Outgoing datagrams
  localparam logic [7:0] IPV4_TTL = 8'd128;

  typedef enum logic [7:0] {
    ICMP = 8'd1,
    TCP  = 8'd6,
    UDP  = 8'd17
  } ip_proto_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_PAYLOAD
  } tx_state_t;

  // Wire order, src_port is sent first
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] chsum;
  } udp_hdr_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    ip_proto_t   proto;
    logic [15:0] payload_length; // IPv4 payload, i.e. the whole datagram
    logic [7:0]  ttl;
    logic [15:0] id;
    logic [15:0] length;         // Total IPv4 length
  } ipv4_meta_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
    logic       err;
  } byte_strm_t;

  typedef struct packed {
    logic [31:0] ipv4_addr;
    logic [15:0] udp_port;
  } dev_t;

endpackage

// File: hdl/udp_top.sv
`timescale 1ns/1ps

module udp_top (
  input  logic                clk,
  input  logic                fsm_rst,
  input  udp_pkg::dev_t       dev,
  input  udp_pkg::byte_strm_t ip_rx,
  input  udp_pkg::ipv4_meta_t ip_rx_meta,
  output udp_pkg::byte_strm_t app_rx,
  output udp_pkg::udp_hdr_t   app_rx_hdr,
  output udp_pkg::ipv4_meta_t app_rx_meta,
  input  logic                tx_rdy,
  input  udp_pkg::byte_strm_t app_tx,
  input  udp_pkg::udp_hdr_t   app_tx_hdr,
  input  udp_pkg::ipv4_meta_t app_tx_meta,
  output logic                tx_req,
  output logic                tx_done,
  output udp_pkg::byte_strm_t ip_tx,
  output udp_pkg::ipv4_meta_t ip_tx_meta
);

  udp_rx u_udp_rx (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .ip_rx       (ip_rx),
    .ip_rx_meta  (ip_rx_meta),
    .dev         (dev),
    .app_rx      (app_rx),
    .app_rx_hdr  (app_rx_hdr),
    .app_rx_meta (app_rx_meta)
  );

  udp_tx u_udp_tx (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .tx_rdy      (tx_rdy),
    .app_tx      (app_tx),
    .app_tx_hdr  (app_tx_hdr),
    .app_tx_meta (app_tx_meta),
    .tx_req      (tx_req),
    .tx_done     (tx_done),
    .ip_tx       (ip_tx),
    .ip_tx_meta  (ip_tx_meta)
  );

endmodule

// File: hdl/udp_tx.sv
`timescale 1ns/1ps

module udp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                tx_rdy,
  input  udp_pkg::byte_strm_t app_tx,
  input  udp_pkg::udp_hdr_t   app_tx_hdr,
  input  udp_pkg::ipv4_meta_t app_tx_meta,
  output logic                tx_req,
  output logic                tx_done,
  output udp_pkg::byte_strm_t ip_tx,
  output udp_pkg::ipv4_meta_t ip_tx_meta
);

  udp_pkg::tx_state_t                   state;
  logic [udp_pkg::UDP_HDR_LEN-1:0][7:0] hdr_sr; // MSB byte goes out first
  logic [2:0]                           hdr_cnt;
  logic                                 hdr_last;
  logic                                 start;

  assign start    = (state == udp_pkg::TX_IDLE) && tx_rdy;
  assign hdr_last = (hdr_cnt == 3'(udp_pkg::UDP_HDR_LEN - 1));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= udp_pkg::TX_IDLE;
      hdr_cnt <= '0;
    end else begin
      case (state)
        udp_pkg::TX_IDLE: begin
          hdr_cnt <= '0;
          if (tx_rdy) begin
            state <= udp_pkg::TX_HDR;
          end
        end
        udp_pkg::TX_HDR: begin
          hdr_cnt <= hdr_cnt + 3'd1;
          if (hdr_last) begin
            state <= udp_pkg::TX_PAYLOAD;
          end
        end
        udp_pkg::TX_PAYLOAD: begin
          if (app_tx.eof) begin
            state <= udp_pkg::TX_IDLE;
          end
        end
        default: state <= udp_pkg::TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      hdr_sr                    <= app_tx_hdr;
      ip_tx_meta.src_ip         <= app_tx_meta.src_ip;
      ip_tx_meta.dst_ip         <= app_tx_meta.dst_ip;
      ip_tx_meta.id             <= app_tx_meta.id;
      ip_tx_meta.proto          <= udp_pkg::UDP;
      ip_tx_meta.ttl            <= udp_pkg::IPV4_TTL;
      ip_tx_meta.payload_length <= app_tx_hdr.length;
      ip_tx_meta.length         <= app_tx_hdr.length + 16'(udp_pkg::IPV4_HDR_LEN);
    end else if (state == udp_pkg::TX_HDR) begin
      hdr_sr <= {hdr_sr[udp_pkg::UDP_HDR_LEN-2:0], 8'h00};
    end
  end

  // Payload passes straight through, no added latency
  always_comb begin
    ip_tx   = '0;
    tx_req  = 1'b0;
    tx_done = 1'b0;
    case (state)
      udp_pkg::TX_HDR: begin
        ip_tx.dat = hdr_sr[udp_pkg::UDP_HDR_LEN-1];
        ip_tx.val = 1'b1;
        ip_tx.sof = (hdr_cnt == 3'd0);
      end
      udp_pkg::TX_PAYLOAD: begin
        ip_tx.dat = app_tx.dat;
        ip_tx.val = 1'b1;
        ip_tx.eof = app_tx.eof;
        ip_tx.err = app_tx.err;
        tx_req    = 1'b1;
        tx_done   = app_tx.eof;
      end
      default: ;
    endcase
  end

endmodule

// File: sources.f
common/udp_pkg.sv
udp_rx/udp_hdr_parser.sv
udp_rx/udp_len_check.sv
udp_rx/udp_rx.sv
hdl/udp_tx.sv
hdl/udp_top.sv
tb/udp_tb_clk.sv
tb/udp_checker.sv
tb/udp_tb.sv

// File: tb/udp_checker.sv
`timescale 1ns/1ps

module udp_checker (
  input logic                clk,
  input logic                fsm_rst,
  input udp_pkg::byte_strm_t app_rx,
  input udp_pkg::byte_strm_t ip_tx,
  input logic                tx_req,
  input logic                tx_done
);

  int assert_fails = 0;

  a_rx_strobes: assert property (@(posedge clk) disable iff (fsm_rst)
    (app_rx.sof || app_rx.eof) |-> app_rx.val)
    else begin
      $error("app_rx sof or eof seen without val");
      assert_fails++;
    end

  a_tx_strobes: assert property (@(posedge clk) disable iff (fsm_rst)
    (ip_tx.sof || ip_tx.eof) |-> ip_tx.val)
    else begin
      $error("ip_tx sof or eof seen without val");
      assert_fails++;
    end

  // Transmit side stays quiet in reset
  a_rst_quiet: assert property (@(posedge clk) fsm_rst |-> (!tx_req && !tx_done))
    else begin
      $error("tx_req or tx_done high during reset");
      assert_fails++;
    end

  a_done_eof: assert property (@(posedge clk) disable iff (fsm_rst) (tx_done == ip_tx.eof))
    else begin
      $error("tx_done and ip_tx.eof disagree");
      assert_fails++;
    end

endmodule

bind udp_top udp_checker u_checker (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .app_rx  (app_rx),
  .ip_tx   (ip_tx),
  .tx_req  (tx_req),
  .tx_done (tx_done)
);

// File: tb/udp_tb.sv
`timescale 1ns/1ps

module udp_tb;

  logic                clk;
  logic                fsm_rst;
  logic                tx_rdy;
  logic                tx_req;
  logic                tx_done;
  udp_pkg::dev_t       dev;
  udp_pkg::byte_strm_t ip_rx;
  udp_pkg::byte_strm_t app_rx;
  udp_pkg::byte_strm_t app_tx;
  udp_pkg::byte_strm_t ip_tx;
  udp_pkg::ipv4_meta_t ip_rx_meta;
  udp_pkg::ipv4_meta_t app_rx_meta;
  udp_pkg::ipv4_meta_t app_tx_meta;
  udp_pkg::ipv4_meta_t ip_tx_meta;
  udp_pkg::udp_hdr_t   app_rx_hdr;
  udp_pkg::udp_hdr_t   app_tx_hdr;

  udp_pkg::udp_hdr_t   exp_hdr;
  udp_pkg::ipv4_meta_t exp_rx_meta;
  udp_pkg::ipv4_meta_t exp_meta;
  udp_pkg::byte_strm_t rx_exp[$]; // Expected bytes over the whole run
  udp_pkg::byte_strm_t tx_exp[$];
  logic [7:0]          rx_pay[$];
  logic [7:0]          tx_pay[$];
  logic [31:0]         lfsr;
  string               test_name;
  int                  rx_pos = 0;
  int                  tx_pos = 0;
  int                  rx_errs = 0;
  int                  cmp_errors = 0;
  int                  chk_errors = 0;
  int                  errs_start;
  int                  rx_errs_start;
  int                  tests = 0;
  int                  failed = 0;

  udp_tb_clk u_clk (.clk(clk));

  udp_top UUT (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [7:0] hdr_byte(input udp_pkg::udp_hdr_t h, input int i);
    logic [15:0] f;
    case (i / 2)
      0: f = h.src_port;
      1: f = h.dst_port;
      2: f = h.length;
      default: f = h.chsum;
    endcase
    return (i % 2 == 0) ? f[15:8] : f[7:0]; // High byte first
  endfunction

  function automatic udp_pkg::byte_strm_t ref_rx(input int k, input int n);
    udp_pkg::byte_strm_t b;
    b     = '0;
    b.dat = rx_pay[k];
    b.val = 1'b1;
    b.sof = (k == 0);
    b.eof = (k == n - 1);
    return b;
  endfunction

  // Whole datagram as it must leave on ip_tx
  function automatic udp_pkg::byte_strm_t ref_tx(input udp_pkg::udp_hdr_t h, input int i,
                                                 input int n);
    udp_pkg::byte_strm_t b;
    b = '0;
    if (i < 8) begin
      b.dat = hdr_byte(h, i);
    end else begin
      b.dat = tx_pay[i-8];
    end
    b.val = 1'b1;
    b.sof = (i == 0);
    b.eof = (i == n + 7);
    return b;
  endfunction

  function automatic udp_pkg::ipv4_meta_t ref_tx_meta(input udp_pkg::udp_hdr_t h,
                                                      input udp_pkg::ipv4_meta_t m);
    udp_pkg::ipv4_meta_t r;
    r        = m;
    r.proto  = udp_pkg::UDP;
    r.ttl    = 8'd128;
    r.length = h.length + 16'd20; // Plus IPv4 header
    return r;
  endfunction

  function automatic logic [111:0] meta_fields(input udp_pkg::ipv4_meta_t m);
    return {m.src_ip, m.dst_ip, m.proto, m.ttl, m.id, m.length};
  endfunction

  function automatic int all_errors();
    return cmp_errors + chk_errors + UUT.u_checker.assert_fails;
  endfunction

  // Values shown as dat with sof and eof in the two low bits
  always @(posedge clk) begin : compare
    logic [9:0] want;
    logic [9:0] got;
    if (!fsm_rst && app_rx.val) begin
      got = {app_rx.dat, app_rx.sof, app_rx.eof};
      if (rx_pos >= rx_exp.size()) begin
        $display("unexpected app_rx byte %h in test %s", app_rx.dat, test_name);
        cmp_errors++;
      end else begin
        want = {rx_exp[rx_pos].dat, rx_exp[rx_pos].sof, rx_exp[rx_pos].eof};
        if (got !== want) begin
          $display("error %s: app_rx byte %0d expected %h actual %h", test_name, rx_pos, want, got);
          cmp_errors++;
        end
        if (app_rx.sof && app_rx_hdr !== exp_hdr) begin
          $display("error %s: app_rx_hdr expected %h actual %h", test_name, exp_hdr, app_rx_hdr);
          cmp_errors++;
        end
        if (app_rx.sof && app_rx_meta !== exp_rx_meta) begin
          $display("error %s: app_rx_meta expected %h actual %h", test_name, exp_rx_meta,
                   app_rx_meta);
          cmp_errors++;
        end
        rx_pos++;
      end
    end
    if (!fsm_rst && ip_tx.val) begin
      got = {ip_tx.dat, ip_tx.sof, ip_tx.eof};
      if (tx_pos >= tx_exp.size()) begin
        $display("unexpected ip_tx byte %h in test %s", ip_tx.dat, test_name);
        cmp_errors++;
      end else begin
        want = {tx_exp[tx_pos].dat, tx_exp[tx_pos].sof, tx_exp[tx_pos].eof};
        if (got !== want) begin
          $display("error %s: ip_tx byte %0d expected %h actual %h", test_name, tx_pos, want, got);
          cmp_errors++;
        end
        if (tx_done !== tx_exp[tx_pos].eof) begin
          $display("error %s: tx_done expected %b actual %b", test_name, tx_exp[tx_pos].eof,
                   tx_done);
          cmp_errors++;
        end
        if (ip_tx.sof && meta_fields(ip_tx_meta) !== meta_fields(exp_meta)) begin
          $display("error %s: ip_tx_meta expected %h actual %h", test_name,
                   meta_fields(exp_meta), meta_fields(ip_tx_meta));
          cmp_errors++;
        end
        tx_pos++;
      end
    end
    if (!fsm_rst && app_rx.err) begin
      rx_errs++;
    end
  end

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic gen_dgram(input logic [15:0] dst, input bit for_tx,
                           output udp_pkg::udp_hdr_t h);
    logic [15:0] v;
    take_bits(16, v);
    h.src_port = v;
    h.dst_port = dst;
    take_bits(4, v);
    h.length = 16'd9 + v; // 1 to 16 payload bytes
    take_bits(16, v);
    h.chsum = v;
    if (for_tx) begin
      tx_pay.delete();
    end else begin
      rx_pay.delete();
    end
    for (int i = 0; i < int'(h.length) - 8; i++) begin
      take_bits(8, v);
      if (for_tx) begin
        tx_pay.push_back(v[7:0]);
      end else begin
        rx_pay.push_back(v[7:0]);
      end
    end
  endtask

  task automatic run_rx(input udp_pkg::udp_hdr_t h, input udp_pkg::ip_proto_t proto,
                        input int extra, input bit deliver);
    int n;
    n = int'(h.length) - 8;
    if (deliver) begin
      exp_hdr                    = h;
      exp_rx_meta                = ip_rx_meta;
      exp_rx_meta.proto          = proto;
      exp_rx_meta.payload_length = h.length + 16'(extra);
      for (int k = 0; k < n; k++) begin
        rx_exp.push_back(ref_rx(k, n));
      end
    end
    for (int i = 0; i < n + 8; i++) begin
      @(negedge clk);
      ip_rx_meta.proto          = proto;
      ip_rx_meta.payload_length = h.length + 16'(extra);
      if (i < 8) begin
        ip_rx.dat = hdr_byte(h, i);
      end else begin
        ip_rx.dat = rx_pay[i-8];
      end
      ip_rx.val = 1'b1;
      ip_rx.sof = (i == 0);
      ip_rx.eof = (i == n + 7);
      ip_rx.err = 1'b0;
    end
    @(negedge clk);
    ip_rx = '0;
  endtask

  task automatic send_tx(input udp_pkg::udp_hdr_t h);
    int n;
    int i;
    int t;
    n = int'(h.length) - 8;
    for (int k = 0; k < n + 8; k++) begin
      tx_exp.push_back(ref_tx(h, k, n));
    end
    exp_meta = ref_tx_meta(h, app_tx_meta);
    @(negedge clk);
    tx_rdy     = 1'b1;
    app_tx_hdr = h;
    @(negedge clk);
    tx_rdy = 1'b0;
    i      = 0;
    t      = 0;
    while (i < n && t < 100) begin
      if (tx_req) begin
        app_tx.dat = tx_pay[i];
        app_tx.val = 1'b1;
        app_tx.sof = (i == 0);
        app_tx.eof = (i == n - 1);
        i++;
      end else begin
        t++;
      end
      @(negedge clk);
    end
    if (i < n) begin
      $display("timed out waiting for tx_req in test %s", test_name);
      chk_errors++;
    end
    app_tx = '0;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_start    = all_errors();
    rx_errs_start = rx_errs;
  endtask

  task automatic end_test(input int exp_err);
    int t;
    t = 0;
    while ((rx_pos < rx_exp.size() || tx_pos < tx_exp.size()) && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (t >= 200) begin
      $display("timed out waiting for output bytes in test %s", test_name);
      chk_errors++;
    end
    repeat (3) @(negedge clk); // Registered outputs trail the input by a cycle
    if (rx_errs - rx_errs_start != exp_err) begin
      $display("error %s: app_rx.err pulses expected %0d actual %0d", test_name, exp_err,
               rx_errs - rx_errs_start);
      chk_errors++;
    end
    tests++;
    if (all_errors() == errs_start) begin
      $display("test %s ok", test_name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", test_name, all_errors() - errs_start);
    end
  endtask

  initial begin : stim
    udp_pkg::udp_hdr_t h;
    udp_pkg::udp_hdr_t h2;
    logic [15:0]       v;
    lfsr        = 32'h667f;
    fsm_rst     = 1'b1;
    tx_rdy      = 1'b0;
    ip_rx       = '0;
    app_tx      = '0;
    app_tx_hdr  = '0;
    dev         = '{ipv4_addr: 32'hc0a8_0001, udp_port: 16'd5000};
    ip_rx_meta  = '{src_ip: 32'hc0a8_0007, dst_ip: 32'hc0a8_0001, proto: udp_pkg::UDP,
                    payload_length: 16'd0, ttl: 8'd64, id: 16'h0001, length: 16'd0};
    app_tx_meta = '{src_ip: 32'hc0a8_0001, dst_ip: 32'hc0a8_0009, proto: udp_pkg::TCP,
                    payload_length: 16'd0, ttl: 8'd1, id: 16'h4d2e, length: 16'd0};
    repeat (5) @(negedge clk);
    fsm_rst = 1'b0;

    start_test("reset_idle");
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      if ({app_rx.val, app_rx.sof, app_rx.eof, app_rx.err, ip_tx.val, ip_tx.sof, ip_tx.eof,
           ip_tx.err, tx_req, tx_done} !== 10'd0) begin
        $display("error %s: strobes expected %b actual %b", test_name, 10'd0,
                 {app_rx.val, app_rx.sof, app_rx.eof, app_rx.err, ip_tx.val, ip_tx.sof,
                  ip_tx.eof, ip_tx.err, tx_req, tx_done});
        chk_errors++;
      end
    end
    end_test(0);

    start_test("rx_match");
    gen_dgram(dev.udp_port, 1'b0, h);
    run_rx(h, udp_pkg::UDP, 0, 1'b1);
    end_test(0);

    start_test("rx_other_port");
    gen_dgram(dev.udp_port ^ 16'h8000, 1'b0, h);
    run_rx(h, udp_pkg::UDP, 0, 1'b0);
    end_test(0);

    start_test("rx_tcp");
    gen_dgram(dev.udp_port, 1'b0, h);
    run_rx(h, udp_pkg::TCP, 3, 1'b0); // Length mismatch ignored for TCP too
    end_test(0);

    start_test("rx_len_err");
    gen_dgram(dev.udp_port, 1'b0, h);
    run_rx(h, udp_pkg::UDP, 3, 1'b1); // IPv4 claims three more bytes
    end_test(1);

    start_test("tx_basic");
    take_bits(16, v);
    gen_dgram(v, 1'b1, h);
    send_tx(h);
    end_test(0);

    start_test("rx_tx_concurrent");
    gen_dgram(dev.udp_port, 1'b0, h);
    take_bits(16, v);
    gen_dgram(v, 1'b1, h2);
    fork
      run_rx(h, udp_pkg::UDP, 0, 1'b1);
      send_tx(h2);
    join
    end_test(0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, all_errors());
    if (all_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb/udp_tb_clk.sv
`timescale 1ns/1ps

module udp_tb_clk (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk; // 100 ns period

endmodule

// File: udp_rx/udp_hdr_parser.sv
`timescale 1ns/1ps

module udp_hdr_parser (
  input  logic                clk,
  input  logic                fsm_rst,
  input  udp_pkg::byte_strm_t in,
  input  udp_pkg::dev_t       dev,
  output udp_pkg::udp_hdr_t   hdr,
  output logic                hdr_done,
  output logic                port_match
);

  logic [udp_pkg::UDP_HDR_LEN-2:0][7:0] sr; // Header bytes seen so far
  logic [3:0]                           cnt;
  logic [3:0]                           idx;
  logic                                 take;
  logic                                 last;
  udp_pkg::udp_hdr_t                    hdr_nxt;

  // A new frame restarts the count even without a clean end
  assign idx     = in.sof ? 4'd0 : cnt;
  assign take    = in.val && (in.sof || !hdr_done);
  assign last    = (idx == 4'(udp_pkg::UDP_HDR_LEN - 1));
  assign hdr_nxt = {sr, in.dat}; // Eighth byte completes the header

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt        <= '0;
      hdr_done   <= 1'b0;
      port_match <= 1'b0;
    end else if (in.err || (in.val && in.eof)) begin
      cnt        <= '0;
      hdr_done   <= 1'b0;
      port_match <= 1'b0;
    end else if (take) begin
      cnt        <= idx + 4'd1;
      hdr_done   <= last;
      port_match <= last && (hdr_nxt.dst_port == dev.udp_port);
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sr <= {sr[udp_pkg::UDP_HDR_LEN-3:0], in.dat};
      if (last) begin
        hdr <= hdr_nxt;
      end
    end
  end

endmodule

// File: udp_rx/udp_len_check.sv
`timescale 1ns/1ps

module udp_len_check (
  input  logic                clk,
  input  logic                fsm_rst,
  input  udp_pkg::byte_strm_t in,
  input  logic [15:0]         payload_length,
  output logic                len_err
);

  logic [15:0] cnt;
  logic [15:0] cnt_nxt;

  // Count including the current byte
  assign cnt_nxt = in.sof ? 16'd1 : cnt + 16'd1;

  // Only judged on the last byte
  assign len_err = in.val && in.eof && (cnt_nxt != payload_length);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt <= '0;
    end else if (in.val) begin
      cnt <= cnt_nxt;
    end
  end

endmodule

// File: udp_rx/udp_rx.sv
`timescale 1ns/1ps

module udp_rx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  udp_pkg::byte_strm_t ip_rx,
  input  udp_pkg::ipv4_meta_t ip_rx_meta,
  input  udp_pkg::dev_t       dev,
  output udp_pkg::byte_strm_t app_rx,
  output udp_pkg::udp_hdr_t   app_rx_hdr,
  output udp_pkg::ipv4_meta_t app_rx_meta
);

  udp_pkg::byte_strm_t rx_g; // Stream restricted to UDP frames
  udp_pkg::udp_hdr_t   hdr;
  logic                is_udp;
  logic                hdr_done;
  logic                port_match;
  logic                len_err;
  logic                in_frame;
  logic                pl_seen;  // First payload byte already delivered
  logic                ip_err;
  logic                frame_end;
  logic                frame_rst;
  logic                pay;

  assign is_udp = (ip_rx_meta.proto == udp_pkg::UDP);

  always_comb begin
    rx_g     = ip_rx;
    rx_g.val = ip_rx.val && is_udp;
    rx_g.sof = ip_rx.val && ip_rx.sof && is_udp;
    rx_g.eof = ip_rx.val && ip_rx.eof && is_udp;
    rx_g.err = ip_rx.err && is_udp;
  end

  assign ip_err    = rx_g.err && (in_frame || rx_g.sof);
  assign frame_end = rx_g.eof || ip_err;
  assign frame_rst = fsm_rst || frame_end; // Back to idle on the next cycle

  // Bytes after the header, only for our port
  assign pay = rx_g.val && hdr_done && port_match;

  udp_hdr_parser u_hdr_parser (
    .clk        (clk),
    .fsm_rst    (frame_rst),
    .in         (rx_g),
    .dev        (dev),
    .hdr        (hdr),
    .hdr_done   (hdr_done),
    .port_match (port_match)
  );

  udp_len_check u_len_check (
    .clk            (clk),
    .fsm_rst        (frame_rst),
    .in             (rx_g),
    .payload_length (ip_rx_meta.payload_length),
    .len_err        (len_err)
  );

  always_ff @(posedge clk) begin
    app_rx.dat <= ip_rx.dat;
    app_rx_hdr <= hdr;
    if (rx_g.sof) begin
      app_rx_meta <= ip_rx_meta;
    end
    if (fsm_rst) begin
      app_rx.val <= 1'b0;
      app_rx.sof <= 1'b0;
      app_rx.eof <= 1'b0;
      app_rx.err <= 1'b0;
      in_frame   <= 1'b0;
      pl_seen    <= 1'b0;
    end else begin
      app_rx.val <= pay;
      app_rx.sof <= pay && !pl_seen;
      app_rx.eof <= pay && rx_g.eof;
      app_rx.err <= len_err || ip_err; // Independent of port
      in_frame   <= !frame_end && (in_frame || rx_g.sof);
      pl_seen    <= !frame_end && (pl_seen || pay);
    end
  end

endmodule
